// File: files.f
hw/soc_pkg.sv
hw/tl_switch.sv
hw/tl_memory.sv
hw/tl_output.sv
hw/soc_top.sv
test/tb_soc.sv

// File: test/tb_soc.sv
// ==============================
// Random-stimulus testbench for the fabric top:
// master driver, reference model, in-order checker
// ==============================
`timescale 1ns/1ps

module tb_soc;

    localparam int XLEN        = 32;
    localparam int SID_WIDTH   = 8;
    localparam int TRACK_DEPTH = 16;
    localparam int MEM_WORDS   = 4096;
    localparam int OUTPUTS     = 6;
    localparam int A_TIMEOUT   = 200;      // Cycles allowed for one A transfer
    localparam int D_TIMEOUT   = 1000;     // Cycles allowed to drain all responses

    // TileLink-UL encodings
    localparam logic [2:0] OP_PUT_FULL = 3'd0;
    localparam logic [2:0] OP_PUT_PART = 3'd1;
    localparam logic [2:0] OP_GET      = 3'd4;
    localparam logic [2:0] D_ACK       = 3'd0;
    localparam logic [2:0] D_ACK_DATA  = 3'd1;

    // Fabric address map
    localparam logic [31:0] MEM_BASE = 32'h0000_0000;
    localparam logic [31:0] MEM_MASK = 32'h0000_FFFF;
    localparam logic [31:0] OUT_BASE = 32'h0002_0000;
    localparam logic [31:0] OUT_MASK = 32'h0000_000F;

    logic                 clk;
    logic                 rst;
    logic                 tl_a_valid;
    logic                 tl_a_ready;
    logic [2:0]           tl_a_opcode;
    logic [2:0]           tl_a_param;
    logic [2:0]           tl_a_size;
    logic [SID_WIDTH-1:0] tl_a_source;
    logic [XLEN-1:0]      tl_a_address;
    logic [XLEN/8-1:0]    tl_a_mask;
    logic [XLEN-1:0]      tl_a_data;
    logic                 tl_d_valid;
    logic                 tl_d_ready;
    logic [2:0]           tl_d_opcode;
    logic [1:0]           tl_d_param;
    logic [2:0]           tl_d_size;
    logic [SID_WIDTH-1:0] tl_d_source;
    logic [XLEN-1:0]      tl_d_data;
    logic                 tl_d_corrupt;
    logic                 tl_d_denied;
    logic [OUTPUTS-1:0]   led;

    // Expected responses, oldest first
    logic [2:0]           q_opcode  [$];
    logic [SID_WIDTH-1:0] q_source  [$];
    logic [2:0]           q_size    [$];
    logic [XLEN-1:0]      q_data    [$];
    logic                 q_denied  [$];
    logic                 q_corrupt [$];

    logic [XLEN-1:0]      shadow_mem [MEM_WORDS];
    logic [OUTPUTS-1:0]   shadow_out;
    logic [SID_WIDTH-1:0] next_source;
    bit                   accepted;
    bit                   stall;         // Random d_ready back-pressure
    int                   max_inflight;
    int unsigned          seed;

    soc_top #(
        .XLEN(XLEN), .SID_WIDTH(SID_WIDTH), .TRACK_DEPTH(TRACK_DEPTH),
        .MEM_WORDS(MEM_WORDS), .OUTPUTS(OUTPUTS)
    ) UUT (
        .clk(clk), .rst(rst),
        .tl_a_valid(tl_a_valid), .tl_a_ready(tl_a_ready), .tl_a_opcode(tl_a_opcode),
        .tl_a_param(tl_a_param), .tl_a_size(tl_a_size), .tl_a_source(tl_a_source),
        .tl_a_address(tl_a_address), .tl_a_mask(tl_a_mask), .tl_a_data(tl_a_data),
        .tl_d_valid(tl_d_valid), .tl_d_ready(tl_d_ready), .tl_d_opcode(tl_d_opcode),
        .tl_d_param(tl_d_param), .tl_d_size(tl_d_size), .tl_d_source(tl_d_source),
        .tl_d_data(tl_d_data), .tl_d_corrupt(tl_d_corrupt), .tl_d_denied(tl_d_denied),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Checking helpers
    // ==============================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_hang(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic int target_of(input logic [31:0] addr);
        if ((addr & ~MEM_MASK) == MEM_BASE)
            return 0;
        if ((addr & ~OUT_MASK) == OUT_BASE)
            return 1;
        return -1;                          // Unmapped
    endfunction

    // ==============================
    // Reference model
    // ==============================
    task automatic model_accept();
        logic [2:0]      op;
        logic [XLEN-1:0] data;
        logic            den;
        logic            cor;
        bit              is_put;
        bit              is_get;
        int              tgt;
        int              w;
        op     = D_ACK;
        data   = '0;
        den    = 1'b0;
        cor    = 1'b0;
        is_put = (tl_a_opcode == OP_PUT_FULL) || (tl_a_opcode == OP_PUT_PART);
        is_get = (tl_a_opcode == OP_GET);
        tgt    = target_of(tl_a_address);
        if (tgt < 0) begin
            den = 1'b1;
            if (is_get) begin
                op  = D_ACK_DATA;
                cor = 1'b1;
            end
        end else if (!is_put && !is_get) begin
            den = 1'b1;                     // No state change
        end else if (tgt == 0) begin
            w = (tl_a_address >> 2) % MEM_WORDS;    // Window bits above alias
            if (is_get) begin
                op   = D_ACK_DATA;
                data = shadow_mem[w];
            end else begin
                for (int b = 0; b < XLEN/8; b++)
                    if (tl_a_mask[b])
                        shadow_mem[w][8*b +: 8] = tl_a_data[8*b +: 8];
            end
        end else begin
            if (is_get) begin
                op   = D_ACK_DATA;
                data = XLEN'(shadow_out);
            end else if (tl_a_mask[0]) begin
                shadow_out = tl_a_data[OUTPUTS-1:0];
            end
        end
        q_opcode.push_back(op);
        q_source.push_back(tl_a_source);
        q_size.push_back(tl_a_size);
        q_data.push_back(data);
        q_denied.push_back(den);
        q_corrupt.push_back(cor);
        if (q_source.size() > max_inflight)
            max_inflight = q_source.size();
        accepted = 1'b1;
    endtask

    task automatic retire();
        if (q_source.size() == 0) begin
            $display("Error at %0t ns: response with source 0x%02h but nothing outstanding",
                     $time, tl_d_source);
            $display("TB FAILED");
            $fatal(1);
        end
        check_value("tl_d_source", tl_d_source, q_source.pop_front());
        check_value("tl_d_opcode", tl_d_opcode, q_opcode.pop_front());
        check_value("tl_d_size", tl_d_size, q_size.pop_front());
        check_value("tl_d_data", tl_d_data, q_data.pop_front());
        check_value("tl_d_denied", tl_d_denied, q_denied.pop_front());
        check_value("tl_d_corrupt", tl_d_corrupt, q_corrupt.pop_front());
        check_value("tl_d_param", tl_d_param, 32'h0);   // Reserved, always zero
    endtask

    // One clock, sampled at a quiet point before the rising edge
    task automatic tick();
        logic [OUTPUTS-1:0] led_exp;
        #15;
        led_exp = ~shadow_out;              // Active-low LEDs
        check_value("led", led, led_exp);
        if (tl_d_valid && tl_d_ready)
            retire();
        if (tl_a_valid && tl_a_ready)
            model_accept();
        @(negedge clk);
        tl_d_ready = stall ? ($urandom % 100 < 55) : 1'b1;
    endtask

    // ==============================
    // Master driver
    // ==============================
    task automatic issue(input logic [2:0] op, input logic [31:0] addr,
                         input logic [3:0] mask, input logic [31:0] data);
        int waited;
        tl_a_opcode  = op;
        tl_a_param   = 3'd0;
        tl_a_size    = 3'($urandom % 3);
        tl_a_source  = next_source;
        tl_a_address = addr;
        tl_a_mask    = mask;
        tl_a_data    = data;
        tl_a_valid   = 1'b1;
        next_source  = next_source + 1'b1;
        accepted     = 1'b0;
        waited       = 0;
        while (!accepted) begin
            if (waited == A_TIMEOUT)
                report_hang("A-channel request was never accepted");
            tick();
            waited++;
        end
        tl_a_valid = 1'b0;
    endtask

    function automatic logic [31:0] mem_addr(input int slot);
        logic [11:0] idx;
        idx = 12'(slot * 257);              // Slots spread over the array
        return {16'h0000, 2'($urandom % 4), idx, 2'b00};
    endfunction

    function automatic logic [31:0] out_addr();
        return {28'h0002000, 2'($urandom % 4), 2'b00};
    endfunction

    function automatic logic [31:0] bad_addr();
        logic [31:0] r;
        r = $urandom;
        case (r % 3)
            0:       return 32'h0001_0000 | (r & 32'h0000_FFFC);
            1:       return 32'h0002_0010 | (r & 32'h0000_FFFC);
            default: return 32'h8000_0000 | (r & 32'h7FFF_FFFC);
        endcase
    endfunction

    function automatic logic [2:0] bad_opcode();
        case ($urandom % 5)
            0:       return 3'd2;
            1:       return 3'd3;
            2:       return 3'd5;
            3:       return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    // Kind 0 memory, 1 LED register, 2 unmapped, 3 unsupported opcode
    task automatic random_request(input int kind);
        logic [2:0] op;
        logic [3:0] mask;
        mask = 4'($urandom);
        case ($urandom % 3)
            0:       op = OP_PUT_FULL;
            1:       op = OP_PUT_PART;
            default: op = OP_GET;
        endcase
        case (kind)
            0:       issue(op, mem_addr($urandom % 16), mask, $urandom);
            1:       issue(op, out_addr(), mask, $urandom);
            2:       issue(op, bad_addr(), mask, $urandom);
            default: issue(bad_opcode(), ($urandom % 2) ? mem_addr($urandom % 16) : out_addr(),
                           mask, $urandom);
        endcase
    endtask

    task automatic drain();
        int waited;
        stall      = 1'b0;
        tl_d_ready = 1'b1;
        waited     = 0;
        while (q_source.size() != 0) begin
            if (waited == D_TIMEOUT)
                report_hang("outstanding responses never came back on the D channel");
            tick();
            waited++;
        end
        repeat (4) tick();                  // Any extra response shows up here
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        seed         = 32'h86521bc4;
        void'($urandom(seed));
        rst          = 1'b1;
        tl_a_valid   = 1'b0;
        tl_a_opcode  = 3'd0;
        tl_a_param   = 3'd0;
        tl_a_size    = 3'd0;
        tl_a_source  = '0;
        tl_a_address = '0;
        tl_a_mask    = '0;
        tl_a_data    = '0;
        tl_d_ready   = 1'b1;
        shadow_out   = '0;
        next_source  = '0;
        stall        = 1'b0;
        max_inflight = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #15;
        check_value("led", led, 32'h3F);
        check_value("tl_d_valid", tl_d_valid, 32'h0);
        check_value("tl_a_ready", tl_a_ready, 32'h1);
        @(negedge clk);

        // Known contents in every memory slot the test reads
        for (int s = 0; s < 16; s++)
            issue(OP_PUT_FULL, mem_addr(s), 4'hF, $urandom);
        for (int i = 0; i < 120; i++)
            random_request(0);
        drain();

        for (int i = 0; i < 40; i++)
            random_request(1);
        drain();

        // Denied paths, then read back to see nothing moved
        for (int i = 0; i < 40; i++)
            random_request(2 + i % 2);
        for (int s = 0; s < 16; s++)
            issue(OP_GET, mem_addr(s), 4'hF, 32'h0);
        issue(OP_GET, out_addr(), 4'hF, 32'h0);
        drain();

        // Mixed traffic under D back-pressure
        stall = 1'b1;
        for (int i = 0; i < 300; i++) begin
            random_request($urandom % 4);
            if ($urandom % 8 == 0)
                tick();
        end
        drain();

        if (max_inflight < 2) begin
            $display("Error: never more than one request was in flight");
            $display("TB FAILED");
            $fatal(1);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: hw/soc_top.sv
// ===========================
// Fabric top: switch, data memory,
// LED register, active-low LEDs
// ===========================
`timescale 1ns/1ps

module soc_top #(
    parameter int XLEN        = soc_pkg::XLEN_DEFAULT,
    parameter int SID_WIDTH   = soc_pkg::SID_WIDTH_DEFAULT,
    parameter int TRACK_DEPTH = soc_pkg::TRACK_DEPTH_DEFAULT,
    parameter int MEM_WORDS   = 4096,
    parameter int OUTPUTS     = 6
) (
    input  logic                         clk,
    input  logic                         rst,
    // Master A channel
    input  logic                         tl_a_valid,
    output logic                         tl_a_ready,
    input  logic [soc_pkg::OPCODE_W-1:0] tl_a_opcode,
    input  logic [2:0]                   tl_a_param,
    input  logic [soc_pkg::OPCODE_W-1:0] tl_a_size,
    input  logic [SID_WIDTH-1:0]         tl_a_source,
    input  logic [XLEN-1:0]              tl_a_address,
    input  logic [XLEN/8-1:0]            tl_a_mask,
    input  logic [XLEN-1:0]              tl_a_data,
    // Master D channel
    output logic                         tl_d_valid,
    input  logic                         tl_d_ready,
    output logic [soc_pkg::OPCODE_W-1:0] tl_d_opcode,
    output logic [1:0]                   tl_d_param,
    output logic [soc_pkg::OPCODE_W-1:0] tl_d_size,
    output logic [SID_WIDTH-1:0]         tl_d_source,
    output logic [XLEN-1:0]              tl_d_data,
    output logic                         tl_d_corrupt,
    output logic                         tl_d_denied,
    output logic [OUTPUTS-1:0]           led
);

    localparam int NS  = soc_pkg::NUM_SLAVES;
    localparam int MEM = soc_pkg::SLAVE_MEM;
    localparam int OUT = soc_pkg::SLAVE_OUT;

    // ===========================
    // Slave-side buses, by slave index
    // ===========================
    logic                         s_a_valid   [NS];
    logic                         s_a_ready   [NS];
    logic [soc_pkg::OPCODE_W-1:0] s_a_opcode  [NS];
    logic [2:0]                   s_a_param   [NS];
    logic [soc_pkg::OPCODE_W-1:0] s_a_size    [NS];
    logic [SID_WIDTH-1:0]         s_a_source  [NS];
    logic [XLEN-1:0]              s_a_address [NS];
    logic [XLEN/8-1:0]            s_a_mask    [NS];
    logic [XLEN-1:0]              s_a_data    [NS];
    logic                         s_d_valid   [NS];
    logic                         s_d_ready   [NS];
    logic [soc_pkg::OPCODE_W-1:0] s_d_opcode  [NS];
    logic [1:0]                   s_d_param   [NS];
    logic [soc_pkg::OPCODE_W-1:0] s_d_size    [NS];
    logic [SID_WIDTH-1:0]         s_d_source  [NS];
    logic [XLEN-1:0]              s_d_data    [NS];
    logic                         s_d_corrupt [NS];
    logic                         s_d_denied  [NS];

    logic [OUTPUTS-1:0]           out_reg;

    assign led = ~out_reg;      // LEDs are active low

    tl_switch #(
        .XLEN(XLEN), .SID_WIDTH(SID_WIDTH), .TRACK_DEPTH(TRACK_DEPTH)
    ) switch_inst (
        .clk(clk), .rst(rst),
        .a_valid(tl_a_valid), .a_ready(tl_a_ready), .a_opcode(tl_a_opcode),
        .a_param(tl_a_param), .a_size(tl_a_size), .a_source(tl_a_source),
        .a_address(tl_a_address), .a_mask(tl_a_mask), .a_data(tl_a_data),
        .d_valid(tl_d_valid), .d_ready(tl_d_ready), .d_opcode(tl_d_opcode),
        .d_param(tl_d_param), .d_size(tl_d_size), .d_source(tl_d_source),
        .d_data(tl_d_data), .d_corrupt(tl_d_corrupt), .d_denied(tl_d_denied),
        .s_a_valid(s_a_valid), .s_a_ready(s_a_ready), .s_a_opcode(s_a_opcode),
        .s_a_param(s_a_param), .s_a_size(s_a_size), .s_a_source(s_a_source),
        .s_a_address(s_a_address), .s_a_mask(s_a_mask), .s_a_data(s_a_data),
        .s_d_valid(s_d_valid), .s_d_ready(s_d_ready), .s_d_opcode(s_d_opcode),
        .s_d_param(s_d_param), .s_d_size(s_d_size), .s_d_source(s_d_source),
        .s_d_data(s_d_data), .s_d_corrupt(s_d_corrupt), .s_d_denied(s_d_denied)
    );

    // ===========================
    // Targets
    // ===========================
    tl_memory #(
        .XLEN(XLEN), .SID_WIDTH(SID_WIDTH), .MEM_WORDS(MEM_WORDS)
    ) memory_inst (
        .clk(clk), .rst(rst),
        .a_valid(s_a_valid[MEM]), .a_ready(s_a_ready[MEM]),
        .a_opcode(s_a_opcode[MEM]), .a_param(s_a_param[MEM]),
        .a_size(s_a_size[MEM]), .a_source(s_a_source[MEM]),
        .a_address(s_a_address[MEM]), .a_mask(s_a_mask[MEM]), .a_data(s_a_data[MEM]),
        .d_valid(s_d_valid[MEM]), .d_ready(s_d_ready[MEM]),
        .d_opcode(s_d_opcode[MEM]), .d_param(s_d_param[MEM]),
        .d_size(s_d_size[MEM]), .d_source(s_d_source[MEM]), .d_data(s_d_data[MEM]),
        .d_corrupt(s_d_corrupt[MEM]), .d_denied(s_d_denied[MEM])
    );

    tl_output #(
        .XLEN(XLEN), .SID_WIDTH(SID_WIDTH), .OUTPUTS(OUTPUTS)
    ) output_inst (
        .clk(clk), .rst(rst),
        .a_valid(s_a_valid[OUT]), .a_ready(s_a_ready[OUT]),
        .a_opcode(s_a_opcode[OUT]), .a_param(s_a_param[OUT]),
        .a_size(s_a_size[OUT]), .a_source(s_a_source[OUT]),
        .a_address(s_a_address[OUT]), .a_mask(s_a_mask[OUT]), .a_data(s_a_data[OUT]),
        .d_valid(s_d_valid[OUT]), .d_ready(s_d_ready[OUT]),
        .d_opcode(s_d_opcode[OUT]), .d_param(s_d_param[OUT]),
        .d_size(s_d_size[OUT]), .d_source(s_d_source[OUT]), .d_data(s_d_data[OUT]),
        .d_corrupt(s_d_corrupt[OUT]), .d_denied(s_d_denied[OUT]),
        .outputs(out_reg)
    );

endmodule

// File: hw/tl_output.sv
// ===========================
// TileLink-UL LED output register
// ===========================
`timescale 1ns/1ps

module tl_output #(
    parameter int XLEN      = soc_pkg::XLEN_DEFAULT,
    parameter int SID_WIDTH = soc_pkg::SID_WIDTH_DEFAULT,
    parameter int OUTPUTS   = 6
) (
    input  logic                         clk,
    input  logic                         rst,
    // A channel
    input  logic                         a_valid,
    output logic                         a_ready,
    input  logic [soc_pkg::OPCODE_W-1:0] a_opcode,
    input  logic [2:0]                   a_param,
    input  logic [soc_pkg::OPCODE_W-1:0] a_size,
    input  logic [SID_WIDTH-1:0]         a_source,
    input  logic [XLEN-1:0]              a_address,
    input  logic [XLEN/8-1:0]            a_mask,
    input  logic [XLEN-1:0]              a_data,
    // D channel
    output logic                         d_valid,
    input  logic                         d_ready,
    output logic [soc_pkg::OPCODE_W-1:0] d_opcode,
    output logic [1:0]                   d_param,
    output logic [soc_pkg::OPCODE_W-1:0] d_size,
    output logic [SID_WIDTH-1:0]         d_source,
    output logic [XLEN-1:0]              d_data,
    output logic                         d_corrupt,
    output logic                         d_denied,
    output logic [OUTPUTS-1:0]           outputs
);

    logic a_fire;
    logic in_window;
    logic bad_req;
    logic is_put;
    logic is_get;

    // Whole 16-byte window maps to the one register
    assign in_window = (a_address & ~XLEN'(soc_pkg::SLAVE_MASK[soc_pkg::SLAVE_OUT]))
                       == XLEN'(soc_pkg::SLAVE_BASE[soc_pkg::SLAVE_OUT]);
    assign bad_req   = (a_param != '0) || !in_window;
    assign is_put    = (a_opcode == soc_pkg::PUT_FULL_DATA)
                    || (a_opcode == soc_pkg::PUT_PARTIAL_DATA);
    assign is_get    = (a_opcode == soc_pkg::GET);

    assign a_ready   = !d_valid || d_ready;
    assign a_fire    = a_valid && a_ready;
    assign d_param   = '0;
    assign d_corrupt = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
            outputs <= '0;
        end else begin
            if (a_fire)
                d_valid <= 1'b1;
            else if (d_ready)
                d_valid <= 1'b0;
            if (a_fire && !bad_req && is_put && a_mask[0])
                outputs <= a_data[OUTPUTS-1:0];     // Only byte lane 0 loads
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (a_fire) begin
            d_source <= a_source;
            d_size   <= a_size;
            d_opcode <= (is_get && !bad_req) ? soc_pkg::ACCESS_ACK_DATA
                                             : soc_pkg::ACCESS_ACK;
            d_data   <= (is_get && !bad_req) ? XLEN'(outputs) : '0;
            d_denied <= bad_req || !(is_put || is_get);
        end
    end

endmodule

// File: hw/tl_memory.sv
// ===========================
// TileLink-UL data memory with
// byte-masked writes
// ===========================
`timescale 1ns/1ps

module tl_memory #(
    parameter int XLEN      = soc_pkg::XLEN_DEFAULT,
    parameter int SID_WIDTH = soc_pkg::SID_WIDTH_DEFAULT,
    parameter int MEM_WORDS = 4096
) (
    input  logic                         clk,
    input  logic                         rst,
    // A channel
    input  logic                         a_valid,
    output logic                         a_ready,
    input  logic [soc_pkg::OPCODE_W-1:0] a_opcode,
    input  logic [2:0]                   a_param,
    input  logic [soc_pkg::OPCODE_W-1:0] a_size,
    input  logic [SID_WIDTH-1:0]         a_source,
    input  logic [XLEN-1:0]              a_address,
    input  logic [XLEN/8-1:0]            a_mask,
    input  logic [XLEN-1:0]              a_data,
    // D channel
    output logic                         d_valid,
    input  logic                         d_ready,
    output logic [soc_pkg::OPCODE_W-1:0] d_opcode,
    output logic [1:0]                   d_param,
    output logic [soc_pkg::OPCODE_W-1:0] d_size,
    output logic [SID_WIDTH-1:0]         d_source,
    output logic [XLEN-1:0]              d_data,
    output logic                         d_corrupt,
    output logic                         d_denied
);

    localparam int OFF_W = $clog2(XLEN/8);
    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             a_fire;

    assign idx       = a_address[OFF_W +: IDX_W];   // Upper window bits alias
    assign a_ready   = !d_valid || d_ready;         // One response slot
    assign a_fire    = a_valid && a_ready;
    assign d_param   = '0;
    assign d_corrupt = 1'b0;

    always_ff @(posedge clk) begin
        if (rst)
            d_valid <= 1'b0;
        else if (a_fire)
            d_valid <= 1'b1;
        else if (d_ready)
            d_valid <= 1'b0;
    end

    // ===========================
    // Storage and response payload
    // ===========================
    always_ff @(posedge clk) begin
        if (a_fire) begin
            d_source <= a_source;
            d_size   <= a_size;
            d_opcode <= soc_pkg::ACCESS_ACK;
            d_data   <= '0;
            d_denied <= 1'b0;
            if (a_param != '0) begin
                d_denied <= 1'b1;               // Reserved param must be zero
            end else begin
                case (soc_pkg::tl_a_op_e'(a_opcode))
                    soc_pkg::PUT_FULL_DATA, soc_pkg::PUT_PARTIAL_DATA: begin
                        for (int b = 0; b < XLEN/8; b++) begin
                            if (a_mask[b])
                                mem[idx][8*b +: 8] <= a_data[8*b +: 8];
                        end
                    end
                    soc_pkg::GET: begin
                        d_opcode <= soc_pkg::ACCESS_ACK_DATA;
                        d_data   <= mem[idx];
                    end
                    default: d_denied <= 1'b1;  // Unsupported opcode
                endcase
            end
        end
    end

endmodule

// File: hw/tl_switch.sv
// ===========================
// TileLink-UL switch: decoder, A router,
// in-order D return, error responder
// ===========================
`timescale 1ns/1ps

module tl_switch #(
    parameter int XLEN        = soc_pkg::XLEN_DEFAULT,
    parameter int SID_WIDTH   = soc_pkg::SID_WIDTH_DEFAULT,
    parameter int TRACK_DEPTH = soc_pkg::TRACK_DEPTH_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst,
    // Master A channel
    input  logic                         a_valid,
    output logic                         a_ready,
    input  logic [soc_pkg::OPCODE_W-1:0] a_opcode,
    input  logic [2:0]                   a_param,
    input  logic [soc_pkg::OPCODE_W-1:0] a_size,
    input  logic [SID_WIDTH-1:0]         a_source,
    input  logic [XLEN-1:0]              a_address,
    input  logic [XLEN/8-1:0]            a_mask,
    input  logic [XLEN-1:0]              a_data,
    // Master D channel
    output logic                         d_valid,
    input  logic                         d_ready,
    output logic [soc_pkg::OPCODE_W-1:0] d_opcode,
    output logic [1:0]                   d_param,
    output logic [soc_pkg::OPCODE_W-1:0] d_size,
    output logic [SID_WIDTH-1:0]         d_source,
    output logic [XLEN-1:0]              d_data,
    output logic                         d_corrupt,
    output logic                         d_denied,
    // Slave A channels
    output logic                         s_a_valid   [soc_pkg::NUM_SLAVES],
    input  logic                         s_a_ready   [soc_pkg::NUM_SLAVES],
    output logic [soc_pkg::OPCODE_W-1:0] s_a_opcode  [soc_pkg::NUM_SLAVES],
    output logic [2:0]                   s_a_param   [soc_pkg::NUM_SLAVES],
    output logic [soc_pkg::OPCODE_W-1:0] s_a_size    [soc_pkg::NUM_SLAVES],
    output logic [SID_WIDTH-1:0]         s_a_source  [soc_pkg::NUM_SLAVES],
    output logic [XLEN-1:0]              s_a_address [soc_pkg::NUM_SLAVES],
    output logic [XLEN/8-1:0]            s_a_mask    [soc_pkg::NUM_SLAVES],
    output logic [XLEN-1:0]              s_a_data    [soc_pkg::NUM_SLAVES],
    // Slave D channels
    input  logic                         s_d_valid   [soc_pkg::NUM_SLAVES],
    output logic                         s_d_ready   [soc_pkg::NUM_SLAVES],
    input  logic [soc_pkg::OPCODE_W-1:0] s_d_opcode  [soc_pkg::NUM_SLAVES],
    input  logic [1:0]                   s_d_param   [soc_pkg::NUM_SLAVES],
    input  logic [soc_pkg::OPCODE_W-1:0] s_d_size    [soc_pkg::NUM_SLAVES],
    input  logic [SID_WIDTH-1:0]         s_d_source  [soc_pkg::NUM_SLAVES],
    input  logic [XLEN-1:0]              s_d_data    [soc_pkg::NUM_SLAVES],
    input  logic                         s_d_corrupt [soc_pkg::NUM_SLAVES],
    input  logic                         s_d_denied  [soc_pkg::NUM_SLAVES]
);

    localparam int NS    = soc_pkg::NUM_SLAVES;
    localparam int SEL_W = (NS > 1) ? $clog2(NS) : 1;
    localparam int PTR_W = (TRACK_DEPTH > 1) ? $clog2(TRACK_DEPTH) : 1;

    logic                         mapped;
    logic [SEL_W-1:0]             a_sel;
    logic                         a_fire;
    logic                         d_fire;
    logic                         full;
    logic                         empty;
    logic [PTR_W-1:0]             wr_ptr;
    logic [PTR_W-1:0]             rd_ptr;
    logic [PTR_W:0]               count;
    logic                         h_err;
    logic [SEL_W-1:0]             h_sel;

    // Tracking FIFO, one entry per accepted request
    logic                         trk_err    [TRACK_DEPTH];
    logic [SEL_W-1:0]             trk_sel    [TRACK_DEPTH];
    logic                         trk_get    [TRACK_DEPTH];
    logic [SID_WIDTH-1:0]         trk_source [TRACK_DEPTH];
    logic [soc_pkg::OPCODE_W-1:0] trk_size   [TRACK_DEPTH];

    // ===========================
    // Address decode and A routing
    // ===========================
    always_comb begin
        mapped = 1'b0;
        a_sel  = '0;
        for (int i = 0; i < NS; i++) begin
            if (!mapped && ((a_address & ~XLEN'(soc_pkg::SLAVE_MASK[i]))
                            == XLEN'(soc_pkg::SLAVE_BASE[i]))) begin
                mapped = 1'b1;
                a_sel  = SEL_W'(i);
            end
        end
    end

    assign full    = (count == (PTR_W+1)'(TRACK_DEPTH));
    assign empty   = (count == '0);
    assign a_ready = !full && (!mapped || s_a_ready[a_sel]);  // Unmapped taken at once
    assign a_fire  = a_valid && a_ready;

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            s_a_valid[i]   = a_valid && !full && mapped && (a_sel == SEL_W'(i));
            s_a_opcode[i]  = a_opcode;
            s_a_param[i]   = a_param;
            s_a_size[i]    = a_size;
            s_a_source[i]  = a_source;
            s_a_address[i] = a_address;
            s_a_mask[i]    = a_mask;
            s_a_data[i]    = a_data;
        end
    end

    // ===========================
    // Tracking FIFO
    // ===========================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (a_fire)
                wr_ptr <= (wr_ptr == PTR_W'(TRACK_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (d_fire)
                rd_ptr <= (rd_ptr == PTR_W'(TRACK_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({a_fire, d_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            trk_err[wr_ptr]    <= !mapped;
            trk_sel[wr_ptr]    <= a_sel;
            trk_get[wr_ptr]    <= (a_opcode == soc_pkg::GET);
            trk_source[wr_ptr] <= a_source;
            trk_size[wr_ptr]   <= a_size;
        end
    end

    // ===========================
    // In-order D return
    // ===========================
    assign h_err  = trk_err[rd_ptr];
    assign h_sel  = trk_sel[rd_ptr];
    assign d_fire = d_valid && d_ready;

    always_comb begin
        // Only the slave at the FIFO head may drain
        for (int i = 0; i < NS; i++)
            s_d_ready[i] = d_ready && !empty && !h_err && (h_sel == SEL_W'(i));

        if (h_err) begin
            // Locally generated denied response
            d_valid   = !empty;
            d_opcode  = trk_get[rd_ptr] ? soc_pkg::ACCESS_ACK_DATA : soc_pkg::ACCESS_ACK;
            d_param   = '0;
            d_size    = trk_size[rd_ptr];
            d_source  = trk_source[rd_ptr];
            d_data    = '0;
            d_corrupt = trk_get[rd_ptr];
            d_denied  = 1'b1;
        end else begin
            d_valid   = !empty && s_d_valid[h_sel];
            d_opcode  = s_d_opcode[h_sel];
            d_param   = s_d_param[h_sel];
            d_size    = s_d_size[h_sel];
            d_source  = s_d_source[h_sel];
            d_data    = s_d_data[h_sel];
            d_corrupt = s_d_corrupt[h_sel];
            d_denied  = s_d_denied[h_sel];
        end
    end

endmodule

// File: hw/soc_pkg.sv
// ===========================
// Bus widths, TileLink opcodes
// and the fabric address map
// ===========================
package soc_pkg;

    // Default widths
    localparam int XLEN_DEFAULT      = 32;
    localparam int SID_WIDTH_DEFAULT = 8;
    localparam int OPCODE_W          = 3;   // Opcode and size fields

    // ===========================
    // TileLink-UL opcodes
    // ===========================
    typedef enum logic [OPCODE_W-1:0] {
        PUT_FULL_DATA    = 3'd0,
        PUT_PARTIAL_DATA = 3'd1,
        GET              = 3'd4
    } tl_a_op_e;

    typedef enum logic [OPCODE_W-1:0] {
        ACCESS_ACK      = 3'd0,
        ACCESS_ACK_DATA = 3'd1
    } tl_d_op_e;

    // ===========================
    // Address map
    // ===========================
    localparam int NUM_SLAVES = 2;
    localparam int SLAVE_MEM  = 0;
    localparam int SLAVE_OUT  = 1;

    // Hit when address matches base outside the mask bits
    localparam logic [31:0] SLAVE_BASE [NUM_SLAVES] = '{
        32'h0000_0000,      // Data memory
        32'h0002_0000       // LED register
    };
    localparam logic [31:0] SLAVE_MASK [NUM_SLAVES] = '{
        32'h0000_FFFF,
        32'h0000_000F
    };

    // Outstanding requests tracked by the switch
    localparam int TRACK_DEPTH_DEFAULT = 16;

endpackage
